// File: hdl/serv_isa_pkg.sv
package serv_isa_pkg;

   localparam int XLEN       = 32;
   localparam int REG_ADDR_W = 5;
   localparam int OPCODE_W   = 7;
   localparam int FUNCT3_W   = 3;
   localparam int FUNCT7_W   = 7;

   typedef logic [XLEN-1:0]       word_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [OPCODE_W-1:0]   opcode_t;
   typedef logic [FUNCT3_W-1:0]   funct3_t;
   typedef logic [FUNCT7_W-1:0]   funct7_t;

   // Field positions in the instruction word
   localparam int RD_LSB  = 7;
   localparam int F3_LSB  = 12;
   localparam int RS1_LSB = 15;
   localparam int RS2_LSB = 20;
   localparam int F7_LSB  = 25;

   // Immediate field widths, both taken from the top of the word
   localparam int IMM_I_W = 12;
   localparam int IMM_U_W = 20;

   // Major opcodes
   localparam opcode_t OP_REG = 7'b0110011;
   localparam opcode_t OP_IMM = 7'b0010011;
   localparam opcode_t OP_LUI = 7'b0110111;

   localparam funct3_t F3_ADD = 3'b000;
   localparam funct3_t F3_XOR = 3'b100;
   localparam funct3_t F3_OR  = 3'b110;
   localparam funct3_t F3_AND = 3'b111;

   localparam funct7_t F7_BASE = 7'b0000000;
   localparam funct7_t F7_SUB  = 7'b0100000;

   // Sequential fetch only
   localparam word_t PC_STEP = 32'd4;

endpackage

// File: hdl/serv_core_pkg.sv
package serv_core_pkg;

   // Execute phase strobes
   typedef struct packed {
      logic en;
      logic first;
      logic done;
   } cnt_t;

   // Boolean unit ops, same as funct3[1:0]
   typedef enum logic [1:0] {
      BOOL_XOR = 2'b00,
      BOOL_OR  = 2'b10,
      BOOL_AND = 2'b11
   } bool_op_e;

   // Destination bit source
   typedef enum logic [1:0] {
      RD_SEL_ADD  = 2'd0,
      RD_SEL_BOOL = 2'd1,
      RD_SEL_IMM  = 2'd2
   } rd_sel_e;

   typedef struct packed {
      logic     sub;
      bool_op_e bool_op;
      rd_sel_e  rd_sel;
      logic     op_b_imm;
   } alu_ctrl_t;

   typedef struct packed {
      logic                    rreq;
      serv_isa_pkg::reg_addr_t rreg0;
      serv_isa_pkg::reg_addr_t rreg1;
      logic                    wen;
      serv_isa_pkg::reg_addr_t wreg;
      logic                    wdata;
   } rf_req_t;

   typedef struct packed {
      logic ready;
      logic rdata0;
      logic rdata1;
   } rf_rsp_t;

   typedef struct packed {
      logic                cyc;
      serv_isa_pkg::word_t adr;
   } ibus_req_t;

   typedef struct packed {
      logic                ack;
      serv_isa_pkg::word_t rdt;
   } ibus_rsp_t;

endpackage

// File: hdl/serv_state.sv
`timescale 1ns/1ps

module serv_state (
   input  logic                 i_clk,
   input  logic                 i_reset,
   input  logic                 i_ibus_ack,
   input  logic                 i_rf_ready,
   output logic                 o_ibus_cyc,
   output logic                 o_rf_rreq,
   output serv_core_pkg::cnt_t  o_cnt
);

   localparam int CNT_W = $clog2(serv_isa_pkg::XLEN);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(serv_isa_pkg::XLEN - 1);

   typedef enum logic [1:0] {
      ST_FETCH,
      ST_WAIT,
      ST_EXEC
   } state_e;

   state_e           state;
   logic [CNT_W-1:0] cnt;
   logic             rreq;
   logic             exec;

   // One instruction in flight: fetch, read request, then 32 serial bits
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         state <= ST_FETCH;
         cnt   <= '0;
         rreq  <= 1'b0;
      end else begin
         rreq <= 1'b0;
         case (state)
            ST_FETCH: begin
               if (i_ibus_ack) begin
                  state <= ST_WAIT;
                  rreq  <= 1'b1;
               end
            end
            ST_WAIT: begin
               // Ready may come as early as the request cycle
               if (i_rf_ready) begin
                  state <= ST_EXEC;
               end
            end
            ST_EXEC: begin
               cnt <= cnt + 1'b1;
               if (o_cnt.done) begin
                  state <= ST_FETCH;
               end
            end
            default: begin
               state <= ST_FETCH;
            end
         endcase
      end
   end

   assign exec = (state == ST_EXEC);

   assign o_ibus_cyc = (state == ST_FETCH);
   assign o_rf_rreq  = rreq;

   // Counter wraps back to zero after the last bit
   always_comb begin
      o_cnt.en    = exec;
      o_cnt.first = exec && (cnt == '0);
      o_cnt.done  = exec && (cnt == CNT_LAST);
   end

endmodule

// File: hdl/serv_decode.sv
`timescale 1ns/1ps

module serv_decode (
   input  logic                          i_clk,
   input  logic                          i_ibus_ack,
   input  serv_isa_pkg::word_t           i_ibus_rdt,
   input  serv_core_pkg::cnt_t           i_cnt,
   output serv_isa_pkg::reg_addr_t       o_rs1_addr,
   output serv_isa_pkg::reg_addr_t       o_rs2_addr,
   output serv_isa_pkg::reg_addr_t       o_rd_addr,
   output logic                          o_rd_wen,
   output serv_core_pkg::alu_ctrl_t      o_alu_ctrl,
   output logic                          o_imm
);

   localparam int XLEN    = serv_isa_pkg::XLEN;
   localparam int IMM_I_W = serv_isa_pkg::IMM_I_W;
   localparam int IMM_U_W = serv_isa_pkg::IMM_U_W;

   serv_isa_pkg::word_t   insn;
   serv_isa_pkg::word_t   imm_sr;
   serv_isa_pkg::word_t   imm_i;
   serv_isa_pkg::word_t   imm_u;
   logic                  rdt_is_lui;

   serv_isa_pkg::opcode_t opcode;
   serv_isa_pkg::funct3_t funct3;
   serv_isa_pkg::funct7_t funct7;
   logic                  f3_ok;
   logic                  f7_ok;
   logic                  is_reg;
   logic                  is_imm;
   logic                  is_lui;

   assign imm_i = {{(XLEN-IMM_I_W){i_ibus_rdt[XLEN-1]}}, i_ibus_rdt[XLEN-1 -: IMM_I_W]};
   assign imm_u = {i_ibus_rdt[XLEN-1 -: IMM_U_W], {(XLEN-IMM_U_W){1'b0}}};

   assign rdt_is_lui = (i_ibus_rdt[serv_isa_pkg::OPCODE_W-1:0] == serv_isa_pkg::OP_LUI);

   // Immediate goes out LSB first, one bit per execute cycle
   always_ff @(posedge i_clk) begin
      if (i_ibus_ack) begin
         insn   <= i_ibus_rdt;
         imm_sr <= rdt_is_lui ? imm_u : imm_i;
      end else if (i_cnt.en) begin
         imm_sr <= {imm_sr[XLEN-1], imm_sr[XLEN-1:1]};
      end
   end

   assign o_imm = imm_sr[0];

   assign opcode = insn[serv_isa_pkg::OPCODE_W-1:0];
   assign funct3 = insn[serv_isa_pkg::F3_LSB +: serv_isa_pkg::FUNCT3_W];
   assign funct7 = insn[serv_isa_pkg::F7_LSB +: serv_isa_pkg::FUNCT7_W];

   assign o_rs1_addr = insn[serv_isa_pkg::RS1_LSB +: serv_isa_pkg::REG_ADDR_W];
   assign o_rs2_addr = insn[serv_isa_pkg::RS2_LSB +: serv_isa_pkg::REG_ADDR_W];
   assign o_rd_addr  = insn[serv_isa_pkg::RD_LSB +: serv_isa_pkg::REG_ADDR_W];

   always_comb begin
      f3_ok  = (funct3 == serv_isa_pkg::F3_ADD) || (funct3 == serv_isa_pkg::F3_XOR) ||
               (funct3 == serv_isa_pkg::F3_OR)  || (funct3 == serv_isa_pkg::F3_AND);
      // Only ADD has a SUB variant
      f7_ok  = (funct7 == serv_isa_pkg::F7_BASE) ||
               ((funct7 == serv_isa_pkg::F7_SUB) && (funct3 == serv_isa_pkg::F3_ADD));
      is_reg = (opcode == serv_isa_pkg::OP_REG) && f3_ok && f7_ok;
      is_imm = (opcode == serv_isa_pkg::OP_IMM) && f3_ok;
      is_lui = (opcode == serv_isa_pkg::OP_LUI);
   end

   // x0 is never written
   assign o_rd_wen = (is_reg || is_imm || is_lui) && (o_rd_addr != '0);

   always_comb begin
      o_alu_ctrl.sub      = is_reg && (funct7 == serv_isa_pkg::F7_SUB);
      o_alu_ctrl.op_b_imm = is_imm;

      case (funct3)
         serv_isa_pkg::F3_XOR: o_alu_ctrl.bool_op = serv_core_pkg::BOOL_XOR;
         serv_isa_pkg::F3_OR:  o_alu_ctrl.bool_op = serv_core_pkg::BOOL_OR;
         default:              o_alu_ctrl.bool_op = serv_core_pkg::BOOL_AND;
      endcase

      if (is_lui) begin
         o_alu_ctrl.rd_sel = serv_core_pkg::RD_SEL_IMM;
      end else if (funct3 == serv_isa_pkg::F3_ADD) begin
         o_alu_ctrl.rd_sel = serv_core_pkg::RD_SEL_ADD;
      end else begin
         o_alu_ctrl.rd_sel = serv_core_pkg::RD_SEL_BOOL;
      end
   end

endmodule

// File: hdl/serv_ctrl.sv
`timescale 1ns/1ps

module serv_ctrl #(
   parameter serv_isa_pkg::word_t RESET_PC = '0
) (
   input  logic                 i_clk,
   input  logic                 i_reset,
   input  serv_core_pkg::cnt_t  i_cnt,
   output serv_isa_pkg::word_t  o_ibus_adr
);

   localparam int XLEN = serv_isa_pkg::XLEN;

   serv_isa_pkg::word_t pc;
   serv_isa_pkg::word_t step_sr;
   logic                step_bit;
   logic                carry;
   logic                c_in;
   logic                sum;
   logic                c_out;

   // Step register rotates once per phase and ends where it started
   assign step_bit = step_sr[0];

   assign c_in  = i_cnt.first ? 1'b0 : carry;
   assign sum   = pc[0] ^ step_bit ^ c_in;
   assign c_out = (pc[0] & step_bit) | (c_in & (pc[0] ^ step_bit));

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         pc      <= RESET_PC;
         step_sr <= serv_isa_pkg::PC_STEP;
      end else if (i_cnt.en) begin
         pc      <= {sum, pc[XLEN-1:1]};
         step_sr <= {step_sr[0], step_sr[XLEN-1:1]};
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_cnt.en) begin
         carry <= c_out;
      end
   end

   // Only moves while cyc is low
   assign o_ibus_adr = pc;

endmodule

// File: hdl/serv_alu.sv
`timescale 1ns/1ps

module serv_alu (
   input  logic                      i_clk,
   input  serv_core_pkg::cnt_t       i_cnt,
   input  serv_core_pkg::alu_ctrl_t  i_alu_ctrl,
   input  serv_core_pkg::rf_rsp_t    i_rf_rsp,
   input  logic                      i_imm,
   output logic                      o_rd
);

   logic rs1;
   logic op_b;
   logic b_inv;
   logic carry;
   logic c_in;
   logic sum;
   logic c_out;
   logic bool_q;

   assign rs1  = i_rf_rsp.rdata0;
   assign op_b = i_alu_ctrl.op_b_imm ? i_imm : i_rf_rsp.rdata1;

   // Two's complement subtract: invert b and start with carry set
   assign b_inv = op_b ^ i_alu_ctrl.sub;
   assign c_in  = i_cnt.first ? i_alu_ctrl.sub : carry;
   assign sum   = rs1 ^ b_inv ^ c_in;
   assign c_out = (rs1 & b_inv) | (c_in & (rs1 ^ b_inv));

   always_ff @(posedge i_clk) begin
      if (i_cnt.en) begin
         carry <= c_out;
      end
   end

   always_comb begin
      case (i_alu_ctrl.bool_op)
         serv_core_pkg::BOOL_OR:  bool_q = rs1 | op_b;
         serv_core_pkg::BOOL_AND: bool_q = rs1 & op_b;
         default:                 bool_q = rs1 ^ op_b;
      endcase
   end

   always_comb begin
      case (i_alu_ctrl.rd_sel)
         serv_core_pkg::RD_SEL_ADD:  o_rd = sum;
         serv_core_pkg::RD_SEL_BOOL: o_rd = bool_q;
         serv_core_pkg::RD_SEL_IMM:  o_rd = i_imm;
         default:                    o_rd = 1'b0;
      endcase
   end

endmodule

// File: hdl/serv_top.sv
`timescale 1ns/1ps

module serv_top #(
   parameter serv_isa_pkg::word_t RESET_PC = '0
) (
   input  logic                      clk,
   input  logic                      i_reset,
   output serv_core_pkg::ibus_req_t  o_ibus,
   input  serv_core_pkg::ibus_rsp_t  i_ibus,
   output serv_core_pkg::rf_req_t    o_rf,
   input  serv_core_pkg::rf_rsp_t    i_rf
);

   serv_core_pkg::cnt_t      cnt;
   serv_core_pkg::alu_ctrl_t alu_ctrl;
   serv_isa_pkg::word_t      ibus_adr;
   serv_isa_pkg::reg_addr_t  rs1_addr;
   serv_isa_pkg::reg_addr_t  rs2_addr;
   serv_isa_pkg::reg_addr_t  rd_addr;
   logic                     ibus_cyc;
   logic                     rf_rreq;
   logic                     rd_wen;
   logic                     imm;
   logic                     alu_rd;

   serv_state state (
      .i_clk      (clk),
      .i_reset    (i_reset),
      .i_ibus_ack (i_ibus.ack),
      .i_rf_ready (i_rf.ready),
      .o_ibus_cyc (ibus_cyc),
      .o_rf_rreq  (rf_rreq),
      .o_cnt      (cnt)
   );

   serv_decode decode (
      .i_clk      (clk),
      .i_ibus_ack (i_ibus.ack),
      .i_ibus_rdt (i_ibus.rdt),
      .i_cnt      (cnt),
      .o_rs1_addr (rs1_addr),
      .o_rs2_addr (rs2_addr),
      .o_rd_addr  (rd_addr),
      .o_rd_wen   (rd_wen),
      .o_alu_ctrl (alu_ctrl),
      .o_imm      (imm)
   );

   serv_ctrl #(
      .RESET_PC (RESET_PC)
   ) ctrl (
      .i_clk      (clk),
      .i_reset    (i_reset),
      .i_cnt      (cnt),
      .o_ibus_adr (ibus_adr)
   );

   serv_alu alu (
      .i_clk      (clk),
      .i_cnt      (cnt),
      .i_alu_ctrl (alu_ctrl),
      .i_rf_rsp   (i_rf),
      .i_imm      (imm),
      .o_rd       (alu_rd)
   );

   assign o_ibus.cyc = ibus_cyc;
   assign o_ibus.adr = ibus_adr;

   // Writes stream alongside the reads
   assign o_rf.rreq  = rf_rreq;
   assign o_rf.rreg0 = rs1_addr;
   assign o_rf.rreg1 = rs2_addr;
   assign o_rf.wen   = rd_wen & cnt.en;
   assign o_rf.wreg  = rd_addr;
   assign o_rf.wdata = alu_rd;

endmodule

// File: verification/serv_tb_clk.sv
`timescale 1ns/1ps

module serv_tb_clk #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 2
) (
   output logic o_clk,
   output logic o_reset
);

   initial begin
      o_clk = 1'b0;
      forever #(PERIOD_NS / 2) o_clk = ~o_clk;
   end

   // Released on a falling edge like every other input
   initial begin
      o_reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge o_clk);
      @(negedge o_clk);
      o_reset = 1'b0;
   end

endmodule

// File: verification/serv_tb.sv
`timescale 1ns/1ps

module serv_tb;

   localparam serv_isa_pkg::word_t RESET_PC = '0;
   localparam int MAX_TESTS       = 32;
   localparam int FIELDS          = 6;
   localparam int CYCLES_PER_TEST = 60;
   localparam int XLEN            = serv_isa_pkg::XLEN;
   localparam int REG_W           = serv_isa_pkg::REG_ADDR_W;

   // Column order in the test file
   localparam int F_INSN   = 0;
   localparam int F_RS1    = 1;
   localparam int F_RS2    = 2;
   localparam int F_WEN    = 3;
   localparam int F_RD     = 4;
   localparam int F_RESULT = 5;

   logic                     clk;
   logic                     reset;
   serv_core_pkg::ibus_req_t ibus_req;
   serv_core_pkg::ibus_rsp_t ibus_rsp;
   serv_core_pkg::rf_req_t   rf_req;
   serv_core_pkg::rf_rsp_t   rf_rsp;

   serv_isa_pkg::word_t tests [0:MAX_TESTS*FIELDS-1];
   int num_tests   = 0;
   int seed        = 32'h22b7_4a48;

   serv_tb_clk #(
      .PERIOD_NS    (8),
      .RESET_CYCLES (2)
   ) clk_gen (
      .o_clk   (clk),
      .o_reset (reset)
   );

   serv_top #(
      .RESET_PC (RESET_PC)
   ) dut0 (
      .clk     (clk),
      .i_reset (reset),
      .o_ibus  (ibus_req),
      .i_ibus  (ibus_rsp),
      .o_rf    (rf_req),
      .i_rf    (rf_rsp)
   );

   task automatic report_failure(input string why);
      $display("%s", why);
      $display("*** FAILED ***");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_word(input string name, input serv_isa_pkg::word_t got,
                             input serv_isa_pkg::word_t exp);
      if (got !== exp) begin
         report_failure($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
      end
   endtask

   task automatic check_reg(input string name, input serv_isa_pkg::reg_addr_t got,
                            input serv_isa_pkg::reg_addr_t exp);
      if (got !== exp) begin
         report_failure($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         report_failure($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
      end
   endtask

   initial begin : watchdog
      wait (num_tests > 0);
      repeat (num_tests * CYCLES_PER_TEST) @(posedge clk);
      report_failure("Timeout: the core did not finish all tests in the allowed cycles");
   end

   initial begin : main
      serv_isa_pkg::word_t insn;
      serv_isa_pkg::word_t rs1_val;
      serv_isa_pkg::word_t rs2_val;
      serv_isa_pkg::word_t exp_result;
      serv_isa_pkg::word_t result;
      serv_isa_pkg::word_t fetch_adr;
      serv_isa_pkg::reg_addr_t exp_rd;
      logic exp_wen;
      int ack_delay;
      int ready_delay;

      ibus_rsp = '0;
      rf_rsp   = '0;
      for (int n = 0; n < MAX_TESTS * FIELDS; n++) begin
         tests[n] = 'x;
      end
      $readmemh("verification/serv_tests.txt", tests);
      while (num_tests < MAX_TESTS && !$isunknown(tests[num_tests*FIELDS])) begin
         num_tests++;
      end
      if (num_tests == 0) begin
         report_failure("No tests were read from verification/serv_tests.txt");
      end

      @(negedge reset);
      fetch_adr = RESET_PC;

      for (int t = 0; t < num_tests; t++) begin
         insn       = tests[t*FIELDS + F_INSN];
         rs1_val    = tests[t*FIELDS + F_RS1];
         rs2_val    = tests[t*FIELDS + F_RS2];
         exp_wen    = tests[t*FIELDS + F_WEN][0];
         exp_rd     = tests[t*FIELDS + F_RD][REG_W-1:0];
         exp_result = tests[t*FIELDS + F_RESULT];
         result     = '0;

         // Fetch request must be up and idle on the register side
         check_flag("o_ibus.cyc", ibus_req.cyc, 1'b1);
         check_word("o_ibus.adr", ibus_req.adr, fetch_adr);
         check_flag("o_rf.rreq", rf_req.rreq, 1'b0);
         check_flag("o_rf.wen", rf_req.wen, 1'b0);

         ack_delay = {$random(seed)} % 4;
         repeat (ack_delay) begin
            @(negedge clk);
            check_flag("o_ibus.cyc", ibus_req.cyc, 1'b1);
            check_word("o_ibus.adr", ibus_req.adr, fetch_adr);
         end
         ibus_rsp.ack = 1'b1;
         ibus_rsp.rdt = insn;

         @(negedge clk);
         ibus_rsp.ack = 1'b0;
         ibus_rsp.rdt = '0;
         check_flag("o_ibus.cyc", ibus_req.cyc, 1'b0);
         if (rf_req.rreq !== 1'b1) begin
            report_failure("No register read request in the cycle after the fetch ack");
         end
         // RV32 fields: rs1 in bits 19:15 and rs2 in bits 24:20
         check_reg("o_rf.rreg0", rf_req.rreg0, insn[19:15]);
         check_reg("o_rf.rreg1", rf_req.rreg1, insn[24:20]);

         ready_delay = {$random(seed)} % 4;
         repeat (ready_delay) begin
            @(negedge clk);
            check_flag("o_rf.rreq", rf_req.rreq, 1'b0);
            check_flag("o_rf.wen", rf_req.wen, 1'b0);
         end
         rf_rsp.ready = 1'b1;

         // Operands go out LSB first, write bits are taken at the rising edge
         for (int b = 0; b < XLEN; b++) begin
            @(negedge clk);
            rf_rsp.ready  = 1'b0;
            rf_rsp.rdata0 = rs1_val[b];
            rf_rsp.rdata1 = rs2_val[b];
            @(posedge clk);
            check_flag("o_rf.wen", rf_req.wen, exp_wen);
            if (exp_wen) begin
               check_reg("o_rf.wreg", rf_req.wreg, exp_rd);
            end
            result[b] = rf_req.wdata;
         end

         @(negedge clk);
         rf_rsp.rdata0 = 1'b0;
         rf_rsp.rdata1 = 1'b0;
         if (exp_wen) begin
            check_word("rd write value", result, exp_result);
         end
         fetch_adr = fetch_adr + serv_isa_pkg::PC_STEP;
      end

      // Last fetch after the final instruction
      check_flag("o_ibus.cyc", ibus_req.cyc, 1'b1);
      check_word("o_ibus.adr", ibus_req.adr, fetch_adr);

      $display("*** PASSED ***");
      $finish;
   end

endmodule

// File: verification/serv_tests.txt
// insn     rs1      rs2      wen rd result
// wen is 1 for a register write, result is the expected rd value
002081B3 12345678 11111111 1 03 23456789
407302B3 00000010 00000020 1 05 FFFFFFF0
00A4F433 F0F0F0F0 FF00FF00 1 08 F000F000
00D665B3 12340000 00005678 1 0B 12345678
0107C733 AAAA5555 FFFF0000 1 0E 55555555
FFF10093 00000005 DEADBEEF 1 01 00000004
80028213 00001000 00000000 1 04 00000800
0F057493 12345678 00000000 1 09 00000070
FF06E613 00000005 00000000 1 0C FFFFFFF5
FFF84793 0F0F1234 00000000 1 0F F0F0EDCB
ABCDE8B7 55555555 AAAAAAAA 1 11 ABCDE000
80000937 FFFFFFFF FFFFFFFF 1 12 80000000
00208033 00000001 00000002 0 00 00000000
00000013 00000000 00000000 0 00 00000000
00208463 00000001 00000002 0 08 00000000
002091B3 00000001 00000002 0 03 00000000
4020C1B3 00000001 00000002 0 03 00000000
01FF8FB3 80000001 80000001 1 1F 00000002

// File: sources.f
hdl/serv_isa_pkg.sv
hdl/serv_core_pkg.sv
hdl/serv_state.sv
hdl/serv_decode.sv
hdl/serv_ctrl.sv
hdl/serv_alu.sv
hdl/serv_top.sv
verification/serv_tb_clk.sv
verification/serv_tb.sv

// File: Bender.yml
package:
  name: serv_rv32i_serial

sources:
  - files:
      - hdl/serv_isa_pkg.sv
      - hdl/serv_core_pkg.sv
      - hdl/serv_state.sv
      - hdl/serv_decode.sv
      - hdl/serv_ctrl.sv
      - hdl/serv_alu.sv
      - hdl/serv_top.sv
  - target: test
    files:
      - verification/serv_tb_clk.sv
      - verification/serv_tb.sv
